// File: serializer_pattern.f
+incdir+hdl
hdl/pattern_pkg.sv
hdl/link_pkg.sv
hdl/prbs_generator.sv
hdl/pattern_loader.sv
hdl/pattern_memory.sv
hdl/word_sequencer.sv
hdl/serializer_pattern_top.sv
dv/serializer_pattern_tb.sv

// File: Makefile
# Verilator build for the serializer test-pattern source

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = serializer_pattern_tb
FILE_LIST = serializer_pattern.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_TEXT = Testbench passed
SOURCES   = $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# the run fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/serializer_pattern_tb.sv
/*
 * Testbench for the serializer test-pattern source: clock and reset,
 * LFSR reference model, scenario table, output checks and watchdog
 */
`default_nettype none
`timescale 1ns/1ns

`include "serializer_settings.svh"

module serializer_pattern_tb import link_pkg::*; ();

	localparam int CLOCK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int DEPTH = 2 ** `PATTERN_ADDR_BITS;
	localparam int LOAD_CYCLES = (DEPTH - 1) * `LOAD_STRIDE + 1; // reset fall to loaded
	localparam int ENABLE_DELAY = 2; // loaded to first enabled word
	localparam int ROW_COUNT = 4;
	localparam logic [31:0] RANDOM_SEED = 32'he344_a413;

	// one row of the scenario table
	typedef struct packed {
		logic [15:0] words; // output words to check
		logic mid_reset; // pulse reset somewhere inside the stream
	} scenario_s;

	localparam scenario_s [0:ROW_COUNT-1] SCENARIOS = {
		scenario_s'{16'd300, 1'b0}, // crosses the address wrap
		scenario_s'{16'd100, 1'b1},
		scenario_s'{16'd520, 1'b1}, // two wraps after the reset
		scenario_s'{16'd40, 1'b0}
	};

	logic clock;
	logic reset;
	tx_word_s tx_word;
	logic tx_enable;
	logic loaded;

	logic [`PATTERN_WORD_BITS-1:0] model_words [0:DEPTH-1];

	serializer_pattern_top serializer_pattern_top_inst (
		.clock(clock),
		.reset(reset),
		.tx_word(tx_word),
		.tx_enable(tx_enable),
		.loaded(loaded)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// x^31 + x^28 + 1, shift left, feedback into bit 0
	function automatic logic [`PRBS_BITS-1:0] prbs_step(input logic [`PRBS_BITS-1:0] state);
		return {state[`PRBS_BITS-2:0], state[30] ^ state[27]};
	endfunction

	// word n is the LFSR low word after n strides from the seed
	task automatic build_model();
		logic [`PRBS_BITS-1:0] state;
		state = `PRBS_SEED;
		for (int n = 0; n < DEPTH; n++) begin
			model_words[n] = state[`PATTERN_WORD_BITS-1:0];
			repeat (`LOAD_STRIDE) state = prbs_step(state);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Testbench failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// sample halfway through the cycle, inputs change here too
	task automatic wait_cycle();
		@(posedge clock);
		@(negedge clock);
	endtask

	task automatic check_idle();
		check_value("loaded", 32'(loaded), 32'd0);
		check_value("tx_enable", 32'(tx_enable), 32'd0);
		check_value("tx_word.sync", 32'(tx_word.sync), 32'd0);
		check_value("tx_word.data", 32'(tx_word.data), 32'd0);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (RESET_CYCLES) begin
			wait_cycle();
			check_idle(); // outputs drop right after the first reset edge
		end
		reset = 1'b0;
	endtask

	// exact cycle of loaded and of the enable that follows it
	task automatic check_load();
		for (int cycle = 1; cycle < LOAD_CYCLES; cycle++) begin
			wait_cycle();
			check_idle();
		end
		repeat (ENABLE_DELAY) begin
			wait_cycle();
			check_value("loaded", 32'(loaded), 32'd1);
			check_value("tx_enable", 32'(tx_enable), 32'd0);
			check_value("tx_word.sync", 32'(tx_word.sync), 32'd0);
		end
	endtask

	// index i maps to address i mod depth, sync on every 16th word
	task automatic check_stream(input int count);
		logic [31:0] expected_data;
		logic [31:0] expected_sync;
		for (int i = 0; i < count; i++) begin
			if (i > 0) begin
				wait_cycle();
			end
			expected_data = 32'(model_words[i % DEPTH][`LINK_WORD_BITS-1:0]);
			expected_sync = 32'((i % (1 << `SYNC_BITS)) == 0);
			check_value("tx_enable", 32'(tx_enable), 32'd1);
			check_value("loaded", 32'(loaded), 32'd1);
			check_value("tx_word.data", 32'(tx_word.data), expected_data);
			check_value("tx_word.sync", 32'(tx_word.sync), expected_sync);
		end
	endtask

	task automatic run_scenario(input int index, input scenario_s row);
		int cut;
		apply_reset();
		check_load();
		wait_cycle(); // first enabled word
		if (row.mid_reset) begin
			cut = 1 + int'($urandom() % (32'(row.words) - 32'd1));
			$display("row %0d: reset after %0d of %0d words", index, cut, row.words);
			check_stream(cut);
			apply_reset(); // second load must match the first
			check_load();
			wait_cycle();
		end else begin
			$display("row %0d: %0d words", index, row.words);
		end
		check_stream(int'(row.words));
		wait_cycle(); // leave the row on a sampled edge
	endtask

	// worst case per row, doubled when the row reloads
	function automatic int watchdog_cycles();
		int total;
		int row_cycles;
		total = 0;
		for (int r = 0; r < ROW_COUNT; r++) begin
			row_cycles = RESET_CYCLES + LOAD_CYCLES + ENABLE_DELAY + int'(SCENARIOS[r].words) + 1;
			total += SCENARIOS[r].mid_reset ? 2 * row_cycles : row_cycles;
		end
		return 2 * total;
	endfunction

	initial begin
		#(watchdog_cycles() * CLOCK_PERIOD);
		$display("Simulation timed out before all scenarios finished");
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		void'($urandom(RANDOM_SEED));
		build_model();
		for (int r = 0; r < ROW_COUNT; r++) begin
			run_scenario(r, SCENARIOS[r]);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/serializer_pattern_top.sv
/*
 * Test-pattern source top: LFSR, loader, pattern memory
 * and readout sequencer on one clock
 */
`default_nettype none
`timescale 1ns/1ns

`include "serializer_settings.svh"

module serializer_pattern_top import pattern_pkg::*, link_pkg::*; (
	input logic clock,
	input logic reset,
	output tx_word_s tx_word,
	output logic tx_enable, // serializer data enable
	output logic loaded
);

	logic [`PRBS_BITS-1:0] prbs_state;
	mem_write_s mem_write;
	logic [`PATTERN_ADDR_BITS-1:0] read_address;
	logic [`PATTERN_WORD_BITS-1:0] read_data;

	prbs_generator prbs_generator_inst (
		.clock(clock),
		.reset(reset),
		.prbs_state(prbs_state)
	);

	pattern_loader pattern_loader_inst (
		.clock(clock),
		.reset(reset),
		.prbs_state(prbs_state),
		.mem_write(mem_write),
		.loaded(loaded)
	);

	pattern_memory pattern_memory_inst (
		.clock(clock),
		.mem_write(mem_write),
		.read_address(read_address),
		.read_data(read_data)
	);

	word_sequencer word_sequencer_inst (
		.clock(clock),
		.reset(reset),
		.loaded(loaded),
		.read_address(read_address),
		.read_data(read_data),
		.tx_word(tx_word),
		.tx_enable(tx_enable)
	);

endmodule

`default_nettype wire

// File: hdl/word_sequencer.sv
/*
 * Readout of the pattern memory in address order with wrap,
 * two-stage alignment of sync and enable, output word register
 */
`default_nettype none
`timescale 1ns/1ns

`include "serializer_settings.svh"

module word_sequencer import link_pkg::*; (
	input logic clock,
	input logic reset,
	input logic loaded,
	output logic [`PATTERN_ADDR_BITS-1:0] read_address,
	input logic [`PATTERN_WORD_BITS-1:0] read_data,
	output tx_word_s tx_word,
	output logic tx_enable
);

	logic address_sync;
	logic valid_d1; // read_data holds a real word
	logic sync_d1;

	// start of each sync group
	assign address_sync = (read_address[`SYNC_BITS-1:0] == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			read_address <= '0;
		end else if (loaded) begin
			read_address <= read_address + 1'b1; // wraps at the top
		end
	end

	// stage 1 lines up with the memory read
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_d1 <= 1'b0;
			sync_d1 <= 1'b0;
		end else begin
			valid_d1 <= loaded;
			sync_d1 <= loaded && address_sync;
		end
	end

	// stage 2 is the output register
	always_ff @(posedge clock) begin
		if (reset) begin
			tx_word <= '0;
			tx_enable <= 1'b0;
		end else begin
			tx_enable <= valid_d1;
			tx_word.sync <= sync_d1;
			if (valid_d1) begin
				tx_word.data <= read_data[`LINK_WORD_BITS-1:0];
			end else begin
				tx_word.data <= '0;
			end
		end
	end

	// sync marks only words the serializer actually takes
	sync_in_stream: assert property (
		@(posedge clock) disable iff (reset)
		tx_word.sync |-> tx_enable
	) else $error("sync asserted outside the enabled stream");

endmodule

`default_nettype wire

// File: hdl/pattern_memory.sv
/*
 * Simple dual-port pattern memory, one write port and one
 * registered read port
 */
`default_nettype none
`timescale 1ns/1ns

`include "serializer_settings.svh"

module pattern_memory import pattern_pkg::*; (
	input logic clock,
	input mem_write_s mem_write,
	input logic [`PATTERN_ADDR_BITS-1:0] read_address,
	output logic [`PATTERN_WORD_BITS-1:0] read_data
);

	localparam int DEPTH = 2 ** `PATTERN_ADDR_BITS;

	logic [`PATTERN_WORD_BITS-1:0] storage [0:DEPTH-1];

	always_ff @(posedge clock) begin
		if (mem_write.enable) begin
			storage[mem_write.address] <= mem_write.data;
		end
	end

	// read-before-write on a shared address
	always_ff @(posedge clock) begin
		read_data <= storage[read_address];
	end

endmodule

`default_nettype wire

// File: hdl/pattern_loader.sv
/*
 * Fill FSM: samples the LFSR once per stride and writes each
 * pattern memory address exactly once, then flags the load done
 */
`default_nettype none
`timescale 1ns/1ns

`include "serializer_settings.svh"

module pattern_loader import pattern_pkg::*; (
	input logic clock,
	input logic reset,
	input logic [`PRBS_BITS-1:0] prbs_state,
	output mem_write_s mem_write,
	output logic loaded
);

	localparam int STRIDE_BITS = $clog2(`LOAD_STRIDE);
	localparam logic [STRIDE_BITS-1:0] STRIDE_LAST = STRIDE_BITS'(`LOAD_STRIDE - 1);
	localparam logic [`PATTERN_ADDR_BITS-1:0] LAST_ADDRESS = '1;

	load_state_e load_state;
	logic [STRIDE_BITS-1:0] stride_count;
	logic [`PATTERN_ADDR_BITS-1:0] write_address;
	logic write_strobe;

	// one write each time the stride counter is at zero
	assign write_strobe = (load_state == load_fill) && (stride_count == '0);

	assign mem_write.enable = write_strobe;
	assign mem_write.address = write_address;
	assign mem_write.data = prbs_state[`PATTERN_WORD_BITS-1:0]; // low word of LFSR
	assign loaded = (load_state == load_done);

	always_ff @(posedge clock) begin
		if (reset) begin
			load_state <= load_fill;
			stride_count <= '0;
			write_address <= '0;
		end else begin
			case (load_state)
				load_fill: begin
					if (stride_count == STRIDE_LAST) begin
						stride_count <= '0;
					end else begin
						stride_count <= stride_count + 1'b1;
					end
					if (write_strobe) begin
						write_address <= write_address + 1'b1;
						if (write_address == LAST_ADDRESS) begin
							load_state <= load_done; // memory full
						end
					end
				end
				load_done: begin
					load_state <= load_done; // hold until reset
				end
				default: begin
					load_state <= load_fill;
				end
			endcase
		end
	end

	// once loaded, the memory contents stay frozen until the next reset
	load_frozen: assert property (
		@(posedge clock) disable iff (reset)
		loaded |=> (loaded && !mem_write.enable)
	) else $error("memory write issued after the load finished");

endmodule

`default_nettype wire

// File: hdl/prbs_generator.sv
/*
 * 31-bit Fibonacci LFSR, x^31 + x^28 + 1, one step per clock
 */
`default_nettype none
`timescale 1ns/1ns

`include "serializer_settings.svh"

module prbs_generator (
	input logic clock,
	input logic reset,
	output logic [`PRBS_BITS-1:0] prbs_state
);

	localparam int TAP_HIGH = `PRBS_BITS - 1; // x^31 term
	localparam int TAP_LOW = 27; // x^28 term

	logic feedback;

	assign feedback = prbs_state[TAP_HIGH] ^ prbs_state[TAP_LOW];

	always_ff @(posedge clock) begin
		if (reset) begin
			prbs_state <= `PRBS_SEED;
		end else begin
			prbs_state <= {prbs_state[`PRBS_BITS-2:0], feedback}; // shift left
		end
	end

	// a zero state would lock the LFSR forever
	prbs_nonzero: assert property (
		@(posedge clock) disable iff (reset)
		prbs_state != '0
	) else $error("LFSR reached the all-zero state");

endmodule

`default_nettype wire

// File: hdl/link_pkg.sv
/*
 * Types for the word handed to the serializer parallel bus
 */
`default_nettype none

`include "serializer_settings.svh"

package link_pkg;

	// parallel data plus sync marker, one per clock
	typedef struct packed {
		logic [`LINK_WORD_BITS-1:0] data;
		logic sync; // first word of a sync group
	} tx_word_s;

endpackage

`default_nettype wire

// File: hdl/pattern_pkg.sv
/*
 * Types for pattern generation: loader states and the
 * memory write bundle
 */
`default_nettype none

`include "serializer_settings.svh"

package pattern_pkg;

	// loader FSM
	typedef enum logic {
		load_fill, // memory being filled
		load_done  // all addresses written
	} load_state_e;

	// one memory write, enable is a single-cycle strobe
	typedef struct packed {
		logic enable;
		logic [`PATTERN_ADDR_BITS-1:0] address;
		logic [`PATTERN_WORD_BITS-1:0] data;
	} mem_write_s;

endpackage

`default_nettype wire

// File: hdl/serializer_settings.svh
/*
 * Build-time sizes for the serializer test-pattern source:
 * memory geometry, link width, load stride, sync spacing, LFSR setup
 */
`ifndef SERIALIZER_SETTINGS_SVH
`define SERIALIZER_SETTINGS_SVH

// pattern memory, 256 words of 16 bits
`define PATTERN_ADDR_BITS 8
`define PATTERN_WORD_BITS 16

// parallel bus of the LVDS serializer
`define LINK_WORD_BITS 10

// clocks between memory writes, keeps sampled LFSR words disjoint
`define LOAD_STRIDE 16

// sync fires when this many low read-address bits are zero
`define SYNC_BITS 4

// LFSR length and nonzero start value
`define PRBS_BITS 31
`define PRBS_SEED 31'h1

`endif
